/* Makefile */
TOP = tb_tlul_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* bench/socket_vectors.hex */
// group host opcode address mask wdata source exp_data exp_error
// opcode 0 full put, 1 partial put, 4 get; group ff ends the list
0 0 0 00000010 f deadbeef 05 00000000 0
0 1 0 00000020 f 11223344 11 00000000 0
0 2 0 00000000 f 0badf00d 22 00000000 0
1 0 4 00000010 f 00000000 06 deadbeef 0
1 1 1 00000020 5 aabbccdd 12 00000000 0
1 2 0 00000100 f ffffffff 23 00000000 1
2 0 4 000001fc f 00000000 07 00000000 1
2 1 4 00000020 f 00000000 13 11bb33dd 0
2 2 4 00000000 f 00000000 24 0badf00d 0
3 0 0 00000040 f a0a0a0a0 3f 00000000 0
3 1 0 00000044 f b1b1b1b1 2a 00000000 0
3 2 0 00000048 f c2c2c2c2 15 00000000 0
4 0 4 00000048 f 00000000 01 c2c2c2c2 0
4 1 4 00000040 f 00000000 3e a0a0a0a0 0
4 2 4 00000044 f 00000000 00 b1b1b1b1 0
5 0 0 000000fc f 76543210 08 00000000 0
5 1 1 00000044 a 12345678 30 00000000 0
5 2 4 00000010 f 00000000 09 deadbeef 0
6 0 4 000000fc f 00000000 0a 76543210 0
6 1 4 00000044 f 00000000 31 12b156b1 0
6 2 4 00000200 f 00000000 3a 00000000 1
ff 0 0 00000000 0 00000000 00 00000000 0

/* bench/tb_tlul_subsys.sv */
////////////////////////////////////////////////////////////
// Testbench for the three-host TL-UL subsystem, replays the
// vector file group by group and checks every response
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_tlul_subsys import tlul_pkg::*, socket_pkg::*;;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_RECS   = 32;
  // Words per record in the vector file
  localparam int REC_W      = 9;
  localparam int F_GRP      = 0;
  localparam int F_HOST     = 1;
  localparam int F_OP       = 2;
  localparam int F_ADDR     = 3;
  localparam int F_MASK     = 4;
  localparam int F_WDATA    = 5;
  localparam int F_SRC      = 6;
  localparam int F_EXP      = 7;
  localparam int F_ERR      = 8;
  localparam logic [31:0] END_GRP = 32'hff;
  // This host holds d_ready low for a while on each response
  localparam int STALL_HOST = 1;
  localparam int CYC_PER_REC = 200;

  logic    clk_i = 1'b0;
  logic    rst_n_i;
  tl_h2d_t tl_h_i [NUM_HOSTS];
  tl_d2h_t tl_h_o [NUM_HOSTS];

  logic [31:0] vec_mem [MAX_RECS*REC_W];
  int          num_recs = 0;
  logic        vectors_ready = 1'b0;
  integer      seed = 58405;

  tlul_subsys_top tlul_subsys_top_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tl_h_i  (tl_h_i),
    .tl_h_o  (tl_h_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  function automatic logic [31:0] rec_field(input int r, input int k);
    return vec_mem[r*REC_W + k];
  endfunction

  // Everything a stalled response must keep unchanged
  function automatic logic [63:0] rsp_payload(input tl_d2h_t rsp);
    return 64'({rsp.d_opcode, rsp.d_size, rsp.d_source, rsp.d_data, rsp.d_error});
  endfunction

  // Gets answer with data, puts with a plain ack
  function automatic tl_d_op_e expected_opcode(input tl_a_op_e op);
    if (op == Get) begin
      return AccessAckData;
    end else begin
      return AccessAck;
    end
  endfunction

  // One request and its response on host h, r < 0 means idle
  task automatic run_host(input int h, input int r);
    tl_a_op_e    op;
    logic [31:0] tmp;
    logic [63:0] held;
    int          rnd;
    int          stall;
    if (r >= 0) begin
      tmp = rec_field(r, F_OP);
      op  = tl_a_op_e'(tmp[2:0]);
      @(negedge clk_i);
      tl_h_i[h].a_valid   = 1'b1;
      tl_h_i[h].a_opcode  = op;
      tl_h_i[h].a_size    = 2'd2;
      tmp = rec_field(r, F_SRC);
      tl_h_i[h].a_source  = tmp[7:0];
      tl_h_i[h].a_address = rec_field(r, F_ADDR);
      tmp = rec_field(r, F_MASK);
      tl_h_i[h].a_mask    = tmp[3:0];
      tl_h_i[h].a_data    = rec_field(r, F_WDATA);
      tl_h_i[h].d_ready   = (h != STALL_HOST);
      // Hold the beat until the host FIFO takes it
      @(posedge clk_i);
      while (!tl_h_o[h].a_ready) @(posedge clk_i);
      @(negedge clk_i);
      tl_h_i[h].a_valid = 1'b0;
      @(posedge clk_i);
      while (!tl_h_o[h].d_valid) @(posedge clk_i);
      if (h == STALL_HOST) begin
        held  = rsp_payload(tl_h_o[h]);
        rnd   = $random(seed);
        stall = (rnd & 15) + 1;
        // Response must wait untouched while refused
        repeat (stall) begin
          @(posedge clk_i);
          check_val($sformatf("host%0d d_valid", h), 64'(tl_h_o[h].d_valid), 64'(1));
          check_val($sformatf("host%0d d payload", h), rsp_payload(tl_h_o[h]), held);
        end
        @(negedge clk_i);
        tl_h_i[h].d_ready = 1'b1;
        @(posedge clk_i);
        check_val($sformatf("host%0d d_valid", h), 64'(tl_h_o[h].d_valid), 64'(1));
      end
      // Handshake happens on this edge
      check_val($sformatf("host%0d d_opcode", h), 64'(tl_h_o[h].d_opcode),
                64'(expected_opcode(op)));
      check_val($sformatf("host%0d d_size", h), 64'(tl_h_o[h].d_size), 64'(2));
      check_val($sformatf("host%0d d_source", h), 64'(tl_h_o[h].d_source),
                64'(rec_field(r, F_SRC)));
      check_val($sformatf("host%0d d_data", h), 64'(tl_h_o[h].d_data),
                64'(rec_field(r, F_EXP)));
      check_val($sformatf("host%0d d_error", h), 64'(tl_h_o[h].d_error),
                64'(rec_field(r, F_ERR)));
      @(negedge clk_i);
      tl_h_i[h].d_ready = 1'b0;
    end
  endtask

  // No host may see a second response
  task automatic check_idle();
    repeat (2) begin
      @(posedge clk_i);
      for (int h = 0; h < NUM_HOSTS; h++) begin
        check_val($sformatf("host%0d d_valid", h), 64'(tl_h_o[h].d_valid), 64'(0));
      end
    end
  endtask

  initial begin : main_seq
    int          idx;
    logic [31:0] grp;
    logic [31:0] hval;
    int          grp_rec [NUM_HOSTS];
    rst_n_i = 1'b0;
    for (int h = 0; h < NUM_HOSTS; h++) begin
      tl_h_i[h] = '0;
    end
    $readmemh("bench/socket_vectors.hex", vec_mem);
    while (num_recs < MAX_RECS && rec_field(num_recs, F_GRP) != END_GRP) begin
      num_recs++;
    end
    if (num_recs == 0 || num_recs == MAX_RECS) begin
      abort_run("Vector file is empty or lacks its end marker");
    end
    vectors_ready = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_idle();
    idx = 0;
    while (idx < num_recs) begin
      grp = rec_field(idx, F_GRP);
      for (int h = 0; h < NUM_HOSTS; h++) begin
        grp_rec[h] = -1;
      end
      // Collect this group, one record per host at most
      while (idx < num_recs && rec_field(idx, F_GRP) == grp) begin
        hval = rec_field(idx, F_HOST);
        if (hval >= NUM_HOSTS || grp_rec[hval] >= 0) begin
          abort_run($sformatf("Vector record %0d names a bad or repeated host", idx));
        end
        grp_rec[hval] = idx;
        idx++;
      end
      // All hosts of the group start on the same edge
      fork
        run_host(0, grp_rec[0]);
        run_host(1, grp_rec[1]);
        run_host(2, grp_rec[2]);
      join
      check_idle();
    end
    $display("TESTS PASSED");
    $finish;
  end

  // Budget scales with the number of records
  initial begin : watchdog
    wait (vectors_ready);
    repeat (num_recs * CYC_PER_REC) @(posedge clk_i);
    abort_run($sformatf("Timeout after %0d cycles, a transaction never completed",
                        num_recs * CYC_PER_REC));
  end

endmodule

/* design/rr_arbiter.sv */
////////////////////////////////////////////////////////////
// Round-robin arbiter, grant held while the output stalls
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rr_arbiter import socket_pkg::*; #(
  parameter int unsigned N = NUM_HOSTS
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic [N-1:0] req_i,
  output logic [N-1:0] gnt_o,
  output host_idx_t    idx_o,
  output logic         valid_o,
  input  logic         ready_i
);

  host_idx_t ptr_q;
  host_idx_t lock_idx_q;
  logic      lock_q;
  host_idx_t pick_idx;

  // First requester at or after the priority pointer
  always_comb begin
    int unsigned cand;
    logic        found;
    pick_idx = ptr_q;
    found    = 1'b0;
    for (int unsigned i = 0; i < N; i++) begin
      cand = ptr_q + i;
      if (cand >= N) begin
        cand = cand - N;
      end
      if (!found && req_i[cand]) begin
        found    = 1'b1;
        pick_idx = host_idx_t'(cand);
      end
    end
  end

  assign valid_o = |req_i;
  // Stalled winner keeps the slot so its payload stays on the bus
  assign idx_o   = lock_q ? lock_idx_q : pick_idx;

  // Grant doubles as the accept strobe to the winner
  always_comb begin
    gnt_o = '0;
    if (valid_o && ready_i) begin
      gnt_o[idx_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= valid_o && !ready_i;
      lock_idx_q <= idx_o;
      // Move just past the winner once it is taken
      if (valid_o && ready_i) begin
        ptr_q <= (idx_o == host_idx_t'(N - 1)) ? '0 : idx_o + 1'b1;
      end
    end
  end

endmodule

/* design/socket_pkg.sv */
////////////////////////////////////////////////////////////
// Socket geometry, host count and memory size
////////////////////////////////////////////////////////////

package socket_pkg;

  // Hosts sharing the one device
  localparam int NUM_HOSTS = 3;

  // Low source bits that carry the host index
  localparam int HOST_IDX_W = 2;

  typedef logic [HOST_IDX_W-1:0] host_idx_t;

  // Memory behind the socket, in 32-bit words
  localparam int MEM_WORDS = 64;
  localparam int MEM_AW    = 6;

endpackage

/* design/tlul_fifo.sv */
////////////////////////////////////////////////////////////
// Synchronous ring-buffer FIFO with valid/ready on both
// sides and optional bypass while empty
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tlul_fifo import tlul_pkg::*; #(
  parameter int unsigned Width = TL_DW,
  parameter int unsigned Depth = 2,
  parameter bit          Pass  = 1'b1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  // Pointer and count widths, one bit minimum
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  cnt_q;
  logic             empty;
  logic             bypass;
  logic             push;
  logic             pop;

  assign empty  = (cnt_q == '0);
  // Input goes straight out when nothing is stored
  assign bypass = Pass && empty;

  assign wready_o = (cnt_q < CntW'(Depth));
  assign rvalid_o = bypass ? wvalid_i : !empty;
  assign rdata_o  = bypass ? wdata_i : mem_q[rptr_q];

  // Store unless the beat leaves by bypass this cycle
  assign push = wvalid_i && wready_o && !(bypass && rready_i);
  assign pop  = rvalid_o && rready_i && !bypass;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Net occupancy change
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage array, payload only
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // A stalled output beat stays put until taken
  a_stable_under_stall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o)
  );

endmodule

/* design/tlul_fifo_sync.sv */
////////////////////////////////////////////////////////////
// Request/response FIFO pair cutting one TL-UL link into
// a host side and a device side
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tlul_fifo_sync import tlul_pkg::*; #(
  parameter int unsigned ReqDepth = 2,
  parameter int unsigned RspDepth = 2,
  parameter bit          ReqPass  = 1'b1,
  parameter bit          RspPass  = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  tl_h2d_t tl_h_i,
  output tl_d2h_t tl_h_o,
  output tl_h2d_t tl_d_o,
  input  tl_d2h_t tl_d_i
);

  tl_h2d_t req_wdata;
  tl_h2d_t req_rdata;
  logic    req_wready;
  logic    req_rvalid;
  tl_d2h_t rsp_wdata;
  tl_d2h_t rsp_rdata;
  logic    rsp_wready;
  logic    rsp_rvalid;

  // Handshake bits are regenerated, keep them out of storage
  always_comb begin
    req_wdata         = tl_h_i;
    req_wdata.a_valid = 1'b0;
    req_wdata.d_ready = 1'b0;
    rsp_wdata         = tl_d_i;
    rsp_wdata.d_valid = 1'b0;
    rsp_wdata.a_ready = 1'b0;
  end

  // A channel, host to device
  tlul_fifo #(
    .Width ($bits(tl_h2d_t)),
    .Depth (ReqDepth),
    .Pass  (ReqPass)
  ) u_req_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (tl_h_i.a_valid),
    .wready_o (req_wready),
    .wdata_i  (req_wdata),
    .rvalid_o (req_rvalid),
    .rready_i (tl_d_i.a_ready),
    .rdata_o  (req_rdata)
  );

  // D channel, device to host
  tlul_fifo #(
    .Width ($bits(tl_d2h_t)),
    .Depth (RspDepth),
    .Pass  (RspPass)
  ) u_rsp_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wvalid_i (tl_d_i.d_valid),
    .wready_o (rsp_wready),
    .wdata_i  (rsp_wdata),
    .rvalid_o (rsp_rvalid),
    .rready_i (tl_h_i.d_ready),
    .rdata_o  (rsp_rdata)
  );

  // Device side sees the buffered request and our response space
  always_comb begin
    tl_d_o         = req_rdata;
    tl_d_o.a_valid = req_rvalid;
    tl_d_o.d_ready = rsp_wready;
    tl_h_o         = rsp_rdata;
    tl_h_o.d_valid = rsp_rvalid;
    tl_h_o.a_ready = req_wready;
  end

endmodule

/* design/tlul_mem_dev.sv */
////////////////////////////////////////////////////////////
// TL-UL memory device, word-wide gets and byte-masked puts
// with an error response outside the array
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tlul_mem_dev import tlul_pkg::*, socket_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  tl_h2d_t tl_i,
  output tl_d2h_t tl_o
);

  tl_data_t          mem_q [MEM_WORDS];
  logic [MEM_AW-1:0] word_idx;
  logic              in_range;
  logic              req_acc;
  logic              is_get;

  // Response register
  logic              rsp_valid_q;
  tl_d_op_e          rsp_opcode_q;
  logic [TL_SZW-1:0] rsp_size_q;
  tl_source_t        rsp_source_q;
  tl_data_t          rsp_data_q;
  logic              rsp_error_q;

  // Word address, any bit above the array means out of range
  assign word_idx = tl_i.a_address[MEM_AW+1:2];
  assign in_range = (tl_i.a_address[TL_AW-1:MEM_AW+2] == '0);
  assign is_get   = (tl_i.a_opcode == Get);

  // Take a new request when the response slot frees up
  assign tl_o.a_ready = !rsp_valid_q || tl_i.d_ready;
  assign req_acc      = tl_i.a_valid && tl_o.a_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_acc) begin
      rsp_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_acc) begin
      rsp_opcode_q <= is_get ? AccessAckData : AccessAck;
      rsp_size_q   <= tl_i.a_size;
      rsp_source_q <= tl_i.a_source;
      rsp_error_q  <= !in_range;
      // Zero data on errors and on put acks
      rsp_data_q   <= (is_get && in_range) ? mem_q[word_idx] : '0;
    end
  end

  // Put writes only the enabled bytes
  always_ff @(posedge clk_i) begin
    if (req_acc && !is_get && in_range) begin
      for (int b = 0; b < TL_DBW; b++) begin
        if (tl_i.a_mask[b]) begin
          mem_q[word_idx][8*b +: 8] <= tl_i.a_data[8*b +: 8];
        end
      end
    end
  end

  assign tl_o.d_valid  = rsp_valid_q;
  assign tl_o.d_opcode = rsp_opcode_q;
  assign tl_o.d_size   = rsp_size_q;
  assign tl_o.d_source = rsp_source_q;
  assign tl_o.d_data   = rsp_data_q;
  assign tl_o.d_error  = rsp_error_q;

endmodule

/* design/tlul_pkg.sv */
////////////////////////////////////////////////////////////
// TL-UL field widths, opcodes and channel structs shared
// by every block that touches a TL-UL link
////////////////////////////////////////////////////////////

package tlul_pkg;

  // Bus geometry
  localparam int TL_AW  = 32;
  localparam int TL_DW  = 32;
  localparam int TL_DBW = TL_DW / 8;
  localparam int TL_SZW = 2;
  localparam int TL_AIW = 8;

  typedef logic [TL_AW-1:0]  tl_addr_t;
  typedef logic [TL_DW-1:0]  tl_data_t;
  typedef logic [TL_DBW-1:0] tl_mask_t;
  typedef logic [TL_AIW-1:0] tl_source_t;

  // A channel opcodes, TL-UL subset
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Host to device, A payload plus the D ready
  typedef struct packed {
    logic              a_valid;
    tl_a_op_e          a_opcode;
    logic [TL_SZW-1:0] a_size;
    tl_source_t        a_source;
    tl_addr_t          a_address;
    tl_mask_t          a_mask;
    tl_data_t          a_data;
    logic              d_ready;
  } tl_h2d_t;

  // Device to host, D payload plus the A ready
  typedef struct packed {
    logic              d_valid;
    tl_d_op_e          d_opcode;
    logic [TL_SZW-1:0] d_size;
    tl_source_t        d_source;
    tl_data_t          d_data;
    logic              d_error;
    logic              a_ready;
  } tl_d2h_t;

endpackage

/* design/tlul_socket_m1.sv */
////////////////////////////////////////////////////////////
// TL-UL M:1 socket, arbitrates host requests onto one device
// link and steers responses back by the source ID
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tlul_socket_m1 import tlul_pkg::*, socket_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  tl_h2d_t tl_h_i [NUM_HOSTS],
  output tl_d2h_t tl_h_o [NUM_HOSTS],
  output tl_h2d_t tl_d_o,
  input  tl_d2h_t tl_d_i
);

  tl_h2d_t hreq_fifo_i [NUM_HOSTS];
  tl_h2d_t hreq_fifo_o [NUM_HOSTS];
  tl_d2h_t hrsp_fifo_i [NUM_HOSTS];

  logic [NUM_HOSTS-1:0] hrequest;
  logic [NUM_HOSTS-1:0] hgrant;
  logic [NUM_HOSTS-1:0] dfifo_rspready;

  tl_h2d_t    dreq_fifo_i;
  tl_d2h_t    drsp_fifo_o;
  logic       arb_valid;
  host_idx_t  arb_idx;
  tl_h2d_t    arb_data;
  host_idx_t  rsp_idx;
  tl_source_t hfifo_rspid;

  for (genvar i = 0; i < NUM_HOSTS; i++) begin : gen_host
    tl_source_t shifted_id;

    // Host index goes in the low bits, top bits of the source drop off
    assign shifted_id = {tl_h_i[i].a_source[TL_AIW-HOST_IDX_W-1:0], host_idx_t'(i)};

    always_comb begin
      hreq_fifo_i[i]          = tl_h_i[i];
      hreq_fifo_i[i].a_source = shifted_id;
    end

    tlul_fifo_sync #(
      .ReqDepth (2),
      .RspDepth (2),
      .ReqPass  (1'b1),
      .RspPass  (1'b1)
    ) u_host_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .tl_h_i  (hreq_fifo_i[i]),
      .tl_h_o  (tl_h_o[i]),
      .tl_d_o  (hreq_fifo_o[i]),
      .tl_d_i  (hrsp_fifo_i[i])
    );

    assign hrequest[i] = hreq_fifo_o[i].a_valid;

    // Bits lost to the shift must be unused by the host
    a_src_top_zero: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      tl_h_i[i].a_valid |-> tl_h_i[i].a_source[TL_AIW-1 -: HOST_IDX_W] == '0
    );
  end

  // Pick one buffered request per accepted beat
  rr_arbiter #(
    .N (NUM_HOSTS)
  ) u_req_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (hrequest),
    .gnt_o   (hgrant),
    .idx_o   (arb_idx),
    .valid_o (arb_valid),
    .ready_i (drsp_fifo_o.a_ready)
  );

  assign arb_data = hreq_fifo_o[arb_idx];

  // Winner payload toward the device, d_ready from the addressed host
  always_comb begin
    dreq_fifo_i         = arb_data;
    dreq_fifo_i.a_valid = arb_valid;
    dreq_fifo_i.d_ready = |dfifo_rspready;
  end

  tlul_fifo_sync #(
    .ReqDepth (2),
    .RspDepth (2),
    .ReqPass  (1'b0),
    .RspPass  (1'b0)
  ) u_dev_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tl_h_i  (dreq_fifo_i),
    .tl_h_o  (drsp_fifo_o),
    .tl_d_o  (tl_d_o),
    .tl_d_i  (tl_d_i)
  );

  // Response carries its host in the low source bits
  assign rsp_idx     = drsp_fifo_o.d_source[HOST_IDX_W-1:0];
  // Restore the host's own source value
  assign hfifo_rspid = {{HOST_IDX_W{1'b0}}, drsp_fifo_o.d_source[TL_AIW-1:HOST_IDX_W]};

  for (genvar i = 0; i < NUM_HOSTS; i++) begin : gen_rsp_route
    logic hit;

    assign hit = drsp_fifo_o.d_valid && (rsp_idx == host_idx_t'(i));
    assign dfifo_rspready[i] = hit && hreq_fifo_o[i].d_ready;

    always_comb begin
      hrsp_fifo_i[i]          = drsp_fifo_o;
      hrsp_fifo_i[i].d_valid  = hit;
      hrsp_fifo_i[i].d_source = hfifo_rspid;
      hrsp_fifo_i[i].a_ready  = hgrant[i];
    end
  end

  // Device must echo a source that names a real host
  a_rsp_idx_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    drsp_fifo_o.d_valid |-> rsp_idx < host_idx_t'(NUM_HOSTS)
  );

endmodule

/* design/tlul_subsys_top.sv */
////////////////////////////////////////////////////////////
// Three-host TL-UL subsystem, socket in front of one memory
// device, host ports brought out to the top
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tlul_subsys_top import tlul_pkg::*, socket_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  tl_h2d_t tl_h_i [NUM_HOSTS],
  output tl_d2h_t tl_h_o [NUM_HOSTS]
);

  // Link between socket and memory
  tl_h2d_t tl_dev_h2d;
  tl_d2h_t tl_dev_d2h;

  // Host arbitration and response routing
  tlul_socket_m1 u_socket (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tl_h_i  (tl_h_i),
    .tl_h_o  (tl_h_o),
    .tl_d_o  (tl_dev_h2d),
    .tl_d_i  (tl_dev_d2h)
  );

  // Single memory device
  tlul_mem_dev u_mem_dev (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tl_i    (tl_dev_h2d),
    .tl_o    (tl_dev_d2h)
  );

endmodule

/* src.f */
design/tlul_pkg.sv
design/socket_pkg.sv
design/tlul_fifo.sv
design/tlul_fifo_sync.sv
design/rr_arbiter.sv
design/tlul_socket_m1.sv
design/tlul_mem_dev.sv
design/tlul_subsys_top.sv
bench/tb_tlul_subsys.sv
